/* joy_scan.f */
rtl/joy_pkg.sv
rtl/joy_frame_scanner.sv
rtl/joy_frame_buffer.sv
rtl/arcade_input_map.sv
rtl/joy_input_top.sv
testbench/tb_joy_input.sv

/* Makefile */
# Verilator flow for the joystick front end
# Run from the project root, the testbench reads testbench/joy_golden.txt

TB_TOP  := tb_joy_input
RTL_TOP := joy_input_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f joy_scan.f --top-module $(RTL_TOP)

sim:
	verilator --binary --timing --assert -f joy_scan.f --top-module $(TB_TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^STATUS: PASS$$'

clean:
	rm -rf obj_dir

/* testbench/joy_golden.txt */
// serial(slot 2 in bit 23 .. slot 25 in bit 0) btn joystick_a joystick_b player coin reset_hw reboot
// Expected outputs are the values seen in the inputs_updated cycle that follows the frame
FFFFFF 3 3f 3f 3 3 0 0
7FFFFF 3 3f 3f 3 3 0 0
7FFFFF 3 3f 3f 2 3 0 0
FEFFFF 3 3f 3f 2 3 0 0
FEFFFF 3 3e 3f 3 3 0 0
FFDFFF 3 3e 3f 3 3 0 0
FFDFFF 3 3f 1f 3 3 0 0
FFFEFF 3 3f 1f 3 3 0 0
FFFEFF 3 3f 3e 3 3 0 0
FFFFDF 3 3f 3e 3 3 0 0
FFFFDF 3 3f 3f 3 1 0 0
FFFFFD 3 3f 3f 3 1 0 0
FFFFFD 3 3f 3f 3 2 0 0
EFFFFF 3 3f 3f 3 2 0 0
EFFFFF 3 2f 3f 3 3 0 0
FF7FFF 3 2f 3f 3 3 0 0
FF7FFF 3 3f 3f 1 3 0 0
FFFFFF 3 3f 3f 1 3 0 0
FFFFFF 3 3f 3f 3 3 0 0
FEFFFF 3 3f 3f 3 3 0 0
FFFFFF 3 3f 3f 3 3 0 0
FFFFFF 3 3f 3f 3 3 0 0
FFFFFF 2 3f 3f 3 2 0 0
FFFFFF 1 3f 3f 3 3 1 0
FFFFFB 3 3f 3f 3 3 0 0
FFFFFB 3 3f 3f 3 3 1 0
FFFFBF 3 3f 3f 3 3 1 0
FFFFBF 3 3f 3f 3 3 0 1
FFFFBF 3 3f 3f 3 3 0 0
FFFFFF 3 3f 3f 3 3 0 0
FFFFFF 3 3f 3f 3 3 0 0

/* testbench/tb_joy_input.sv */
// Testbench for the serial joystick front end
// Frames and expected outputs come from testbench/joy_golden.txt, run from the project root
// Golden serial field keeps slot 2 in bit 23 and slot 25 in bit 0
// Inputs change on the falling edge of ena_x and outputs are sampled there

`timescale 1ns/10ps
`default_nettype none

module tb_joy_input;

  import joy_pkg::*;

  localparam int clk_period  = 20;
  localparam int reset_len   = 10;  // Cycles with pll_lckd low
  localparam int max_frames  = 64;
  localparam int cols        = 8;   // Golden fields per frame
  localparam int upd_timeout = 40;

  logic                 ena_x;
  logic                 pll_lckd;
  logic                 joy_data;
  logic [1:0]           btn;
  logic                 joy_load;
  logic [dir_width-1:0] joystick_a;
  logic [dir_width-1:0] joystick_b;
  logic [1:0]           player;
  logic [1:0]           coin;
  logic                 reset_hw;
  logic                 reboot;
  logic                 inputs_updated;

  logic [23:0] golden_mem [0:max_frames*cols-1];
  int          n_frames;
  int          frames_sent;     // Frames whose last slot has been driven
  int          upd_pulses = 0;  // Rising edges of inputs_updated
  int          cyc_cnt = 0;

  joy_input_top dut0 (
    .ena_x          (ena_x),
    .pll_lckd       (pll_lckd),
    .joy_data       (joy_data),
    .btn            (btn),
    .joy_load       (joy_load),
    .joystick_a     (joystick_a),
    .joystick_b     (joystick_b),
    .player         (player),
    .coin           (coin),
    .reset_hw       (reset_hw),
    .reboot         (reboot),
    .inputs_updated (inputs_updated)
  );

  always #(clk_period/2) ena_x = ~ena_x;

  always @(posedge ena_x) cyc_cnt <= cyc_cnt + 1;  // Read only on falling edges

  always @(posedge inputs_updated) upd_pulses <= upd_pulses + 1;

  //////////////////////////////////////////////////
  // Reporting
  //////////////////////////////////////////////////

  task automatic fail_run(input string what);
    $display("ERROR at time %0t: %s", $time, what);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at time %0t: %s is 0x%0h, expected 0x%0h",
               $time, name, actual, expected);
      $display("STATUS: FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // All buttons released, nothing published yet, counter still in slot 0
  task automatic check_idle();
    check_value("joy_load", 32'(joy_load), 32'h0);
    check_value("joystick_a", 32'(joystick_a), 32'h3f);
    check_value("joystick_b", 32'(joystick_b), 32'h3f);
    check_value("player", 32'(player), 32'h3);
    check_value("coin", 32'(coin), 32'h3);
    check_value("reset_hw", 32'(reset_hw), 32'h0);
    check_value("reboot", 32'(reboot), 32'h0);
    check_value("inputs_updated", 32'(inputs_updated), 32'h0);
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Returns on the falling edge inside the slot 0 cycle
  task automatic wait_frame_start();
    int cnt;
    cnt = 0;
    @(negedge ena_x);
    while (joy_load !== 1'b0) begin
      if (cnt >= 2 * frame_len) begin
        fail_run("joy_load did not go low within two frames");
      end else begin
        cnt++;
        @(negedge ena_x);
      end
    end
  endtask

  task automatic drive_frames();
    logic [23:0] bits;
    for (int i = 0; i < n_frames; i++) begin
      bits = golden_mem[i*cols];
      wait_frame_start();
      btn      = golden_mem[i*cols+1][1:0];
      joy_data = 1'b1;
      for (int k = 1; k < frame_len; k++) begin
        @(negedge ena_x);
        check_value("joy_load", 32'(joy_load), 32'h1);  // Shifting in slots 1 to 25
        if (k >= first_slot) begin
          joy_data = bits[frame_len-1-k];  // Sampled at the end of slot k
        end
      end
      frames_sent = i + 1;
    end
    @(negedge ena_x);
    joy_data = 1'b1;
  endtask

  //////////////////////////////////////////////////
  // Response checks
  //////////////////////////////////////////////////

  task automatic check_frames();
    int base;
    int wait_cnt;
    int last_cyc;
    bit upd_seen;
    last_cyc = 0;
    for (int i = 0; i < n_frames; i++) begin
      base     = i * cols;
      wait_cnt = 0;
      while (frames_sent <= i) begin
        if (wait_cnt >= 3 * frame_len) begin
          fail_run("stimulus did not finish a frame in time");
        end else begin
          wait_cnt++;
          @(posedge ena_x);  // Resumes on the slot 25 edge
        end
      end
      // Falling edges from the slot 25 edge to inputs_updated
      wait_cnt = 0;
      upd_seen = 1'b0;
      while (!upd_seen) begin
        if (wait_cnt >= upd_timeout) begin
          fail_run("inputs_updated stayed low for 40 cycles");
        end else begin
          @(negedge ena_x);
          wait_cnt++;
          upd_seen = (inputs_updated === 1'b1);
          if (!upd_seen) begin
            check_value("reboot", 32'(reboot), 32'h0);
          end
        end
      end
      check_value("update latency", wait_cnt, 32'd3);
      if (i > 0) begin
        check_value("update interval", cyc_cnt - last_cyc, frame_len);
      end
      last_cyc = cyc_cnt;
      check_value("joystick_a", 32'(joystick_a), 32'(golden_mem[base+2]));
      check_value("joystick_b", 32'(joystick_b), 32'(golden_mem[base+3]));
      check_value("player", 32'(player), 32'(golden_mem[base+4]));
      check_value("coin", 32'(coin), 32'(golden_mem[base+5]));
      check_value("reset_hw", 32'(reset_hw), 32'(golden_mem[base+6]));
      check_value("reboot", 32'(reboot), 32'(golden_mem[base+7]));
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    ena_x          = 1'b0;
    pll_lckd       = 1'b0;
    joy_data       = 1'b1;
    btn            = 2'b11;
    frames_sent    = 0;
    n_frames       = 0;
    // Empty entries end in f, a real reboot column holds 0 or 1
    for (int a = 0; a < max_frames * cols; a++) begin
      golden_mem[a] = {20'(a), 4'hf};
    end
    $readmemh("testbench/joy_golden.txt", golden_mem);
    while (n_frames < max_frames && golden_mem[n_frames*cols+7] <= 24'd1) begin
      n_frames++;
    end
    if (n_frames == 0) begin
      fail_run("golden file holds no frames");
    end

    repeat (reset_len) @(negedge ena_x);
    pll_lckd = 1'b1;
    check_idle();

    fork
      drive_frames();
      check_frames();
    join

    // One extra update comes from the idle frame scanned right after reset
    if (upd_pulses == n_frames + 1) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("STATUS: FAIL");
      $fatal(1, "inputs_updated pulsed %0d times for %0d frames", upd_pulses, n_frames);
    end
  end

endmodule

`default_nettype wire

/* rtl/joy_input_top.sv */
// Joystick front end: scanner, two-frame debounce and game-core mapping
// Everything runs on ena_x, which also serves as the chain shift clock
// pll_lckd low resets the whole path to the idle mapping
// A new frame reaches the outputs every 26 cycles, there is no back-pressure

`timescale 1ns/10ps
`default_nettype none

module joy_input_top (
  input  logic                         ena_x,
  input  logic                         pll_lckd,
  input  logic                         joy_data,
  input  logic [1:0]                   btn,
  output logic                         joy_load,
  output logic [joy_pkg::dir_width-1:0] joystick_a,
  output logic [joy_pkg::dir_width-1:0] joystick_b,
  output logic [1:0]                   player,
  output logic [1:0]                   coin,
  output logic                         reset_hw,
  output logic                         reboot,
  output logic                         inputs_updated
);

  import joy_pkg::*;

  logic [joy_width-1:0] raw_joy1;
  logic [joy_width-1:0] raw_joy2;
  logic                 frame_done;
  logic [joy_width-1:0] pub_joy1;
  logic [joy_width-1:0] pub_joy2;
  logic                 pub_strobe;

  joy_frame_scanner u_scanner (
    .ena_x      (ena_x),
    .pll_lckd   (pll_lckd),
    .joy_data   (joy_data),
    .joy_load   (joy_load),
    .raw_joy1   (raw_joy1),
    .raw_joy2   (raw_joy2),
    .frame_done (frame_done)
  );

  joy_frame_buffer u_buffer (
    .ena_x      (ena_x),
    .pll_lckd   (pll_lckd),
    .raw_joy1   (raw_joy1),
    .raw_joy2   (raw_joy2),
    .frame_done (frame_done),
    .pub_joy1   (pub_joy1),
    .pub_joy2   (pub_joy2),
    .pub_strobe (pub_strobe)
  );

  arcade_input_map u_map (
    .ena_x          (ena_x),
    .pll_lckd       (pll_lckd),
    .pub_joy1       (pub_joy1),
    .pub_joy2       (pub_joy2),
    .pub_strobe     (pub_strobe),
    .btn            (btn),
    .joystick_a     (joystick_a),
    .joystick_b     (joystick_b),
    .player         (player),
    .coin           (coin),
    .reset_hw       (reset_hw),
    .reboot         (reboot),
    .inputs_updated (inputs_updated)
  );

endmodule

`default_nettype wire

/* rtl/arcade_input_map.sv */
// Maps the published joystick words and board buttons to game-core controls
// btn is asynchronous and active low, it passes a two-flop synchronizer
// All outputs are registered, inputs_updated marks the first cycle of a new publish
// Reboot fires once per falling edge of joystick 2 bit 11

`timescale 1ns/10ps
`default_nettype none

module arcade_input_map (
  input  logic                         ena_x,
  input  logic                         pll_lckd,
  input  logic [joy_pkg::joy_width-1:0] pub_joy1,
  input  logic [joy_pkg::joy_width-1:0] pub_joy2,
  input  logic                         pub_strobe,
  input  logic [1:0]                   btn,
  output logic [joy_pkg::dir_width-1:0] joystick_a,
  output logic [joy_pkg::dir_width-1:0] joystick_b,
  output logic [1:0]                   player,
  output logic [1:0]                   coin,
  output logic                         reset_hw,
  output logic                         reboot,
  output logic                         inputs_updated
);

  import joy_pkg::*;

  logic [1:0] btn_meta;
  logic [1:0] btn_sync;
  logic       reboot_key_q;  // Joystick 2 bit 11 of the last publish

  //////////////////////////////////////////////////
  // Button synchronizer
  //////////////////////////////////////////////////

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      btn_meta <= 2'b11;  // Released
      btn_sync <= 2'b11;
    end else begin
      btn_meta <= btn;
      btn_sync <= btn_meta;
    end
  end

  //////////////////////////////////////////////////
  // Output mapping
  //////////////////////////////////////////////////

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      // Mapping of the idle words with buttons released
      joystick_a     <= joy_idle[dir_width-1:0];
      joystick_b     <= joy_idle[dir_width-1:0];
      player         <= 2'b11;
      coin           <= 2'b11;
      reset_hw       <= 1'b0;
      reboot         <= 1'b0;
      inputs_updated <= 1'b0;
      reboot_key_q   <= joy_idle[11];
    end else begin
      joystick_a     <= pub_joy1[dir_width-1:0];
      joystick_b     <= pub_joy2[dir_width-1:0];
      player         <= {pub_joy2[8], pub_joy1[8]};
      coin           <= {pub_joy2[9], pub_joy1[9] & btn_sync[0]};  // btn[0] masks coin 1
      reset_hw       <= !pub_joy1[11] || !btn_sync[1];
      inputs_updated <= pub_strobe;
      // Edge detect on the published word only
      reboot         <= pub_strobe && reboot_key_q && !pub_joy2[11];
      if (pub_strobe) begin
        reboot_key_q <= pub_joy2[11];
      end
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  a_reboot_with_update : assert property (
    @(posedge ena_x) disable iff (!pll_lckd)
    reboot |-> inputs_updated
  ) else $error("reboot outside an inputs_updated cycle");

endmodule

`default_nettype wire

/* rtl/joy_frame_buffer.sv */
// Two-frame agreement filter between scanner and mapper
// A frame is published only when it equals the frame before it
// pub_strobe marks every judged frame, changed or not
// Both kept frames start as all buttons released

`timescale 1ns/10ps
`default_nettype none

module joy_frame_buffer (
  input  logic                         ena_x,
  input  logic                         pll_lckd,
  input  logic [joy_pkg::joy_width-1:0] raw_joy1,
  input  logic [joy_pkg::joy_width-1:0] raw_joy2,
  input  logic                         frame_done,
  output logic [joy_pkg::joy_width-1:0] pub_joy1,
  output logic [joy_pkg::joy_width-1:0] pub_joy2,
  output logic                         pub_strobe
);

  import joy_pkg::*;

  logic [joy_width-1:0] prev_joy1;  // Last raw frame seen
  logic [joy_width-1:0] prev_joy2;
  logic                 frame_match;

  assign frame_match = (raw_joy1 == prev_joy1) && (raw_joy2 == prev_joy2);

  //////////////////////////////////////////////////
  // Debounce registers
  //////////////////////////////////////////////////

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      prev_joy1  <= joy_idle;
      prev_joy2  <= joy_idle;
      pub_joy1   <= joy_idle;
      pub_joy2   <= joy_idle;
      pub_strobe <= 1'b0;
    end else begin
      pub_strobe <= frame_done;
      if (frame_done) begin
        prev_joy1 <= raw_joy1;
        prev_joy2 <= raw_joy2;
        // A single odd frame never reaches the published words
        if (frame_match) begin
          pub_joy1 <= raw_joy1;
          pub_joy2 <= raw_joy2;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  a_strobe_follows_done : assert property (
    @(posedge ena_x) disable iff (!pll_lckd)
    pub_strobe |-> $past(frame_done)
  ) else $error("pub_strobe without frame_done one cycle earlier");

endmodule

`default_nettype wire

/* rtl/joy_frame_scanner.sv */
// Serial scanner for the parallel-in shift register chain
// The shift clock is ena_x itself, so joy_data must settle before each rising edge
// joy_load is low for the slot 0 cycle only, one strobe per 26-cycle frame
// Raw words hold their last sampled value and are stable while frame_done is high

`timescale 1ns/10ps
`default_nettype none

module joy_frame_scanner (
  input  logic                         ena_x,
  input  logic                         pll_lckd,
  input  logic                         joy_data,
  output logic                         joy_load,
  output logic [joy_pkg::joy_width-1:0] raw_joy1,
  output logic [joy_pkg::joy_width-1:0] raw_joy2,
  output logic                         frame_done
);

  import joy_pkg::*;

  localparam int slot_bits = $clog2(frame_len);
  localparam logic [slot_bits-1:0] last_slot = slot_bits'(frame_len - 1);

  logic [slot_bits-1:0] slot_cnt;

  //////////////////////////////////////////////////
  // Slot counter and load strobe
  //////////////////////////////////////////////////

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      slot_cnt   <= '0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= (slot_cnt == last_slot);  // High in the slot 0 cycle
      if (slot_cnt == last_slot) begin
        slot_cnt <= '0;
      end else begin
        slot_cnt <= slot_cnt + 1'b1;
      end
    end
  end

  // Chain latches its parallel inputs while load is low
  assign joy_load = (slot_cnt != '0);

  //////////////////////////////////////////////////
  // Serial bit scatter
  //////////////////////////////////////////////////

  // Index counts data slots only, negative before the first one
  always_ff @(posedge ena_x) begin
    case (int'(slot_cnt) - first_slot)
      // Controller 1, main byte
      0:  raw_joy1[8]  <= joy_data;
      1:  raw_joy1[6]  <= joy_data;
      2:  raw_joy1[5]  <= joy_data;
      3:  raw_joy1[4]  <= joy_data;
      4:  raw_joy1[3]  <= joy_data;
      5:  raw_joy1[2]  <= joy_data;
      6:  raw_joy1[1]  <= joy_data;
      7:  raw_joy1[0]  <= joy_data;
      // Controller 2, main byte
      8:  raw_joy2[8]  <= joy_data;
      9:  raw_joy2[6]  <= joy_data;
      10: raw_joy2[5]  <= joy_data;
      11: raw_joy2[4]  <= joy_data;
      12: raw_joy2[3]  <= joy_data;
      13: raw_joy2[2]  <= joy_data;
      14: raw_joy2[1]  <= joy_data;
      15: raw_joy2[0]  <= joy_data;
      // Extra buttons sit at the tail of the chain
      16: raw_joy2[10] <= joy_data;
      17: raw_joy2[11] <= joy_data;  // Reboot request
      18: raw_joy2[9]  <= joy_data;  // Coin 2
      19: raw_joy2[7]  <= joy_data;
      20: raw_joy1[10] <= joy_data;
      21: raw_joy1[11] <= joy_data;  // Hardware reset request
      22: raw_joy1[9]  <= joy_data;  // Coin 1
      23: raw_joy1[7]  <= joy_data;
      default: ;                     // Slots 0 and 1
    endcase
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // One load strobe per frame, then frame_len-1 cycles of shifting
  a_load_period : assert property (
    @(posedge ena_x) disable iff (!pll_lckd)
    !joy_load |=> joy_load [*frame_len-1] ##1 !joy_load
  ) else $error("joy_load period is not %0d cycles", frame_len);

endmodule

`default_nettype wire

/* rtl/joy_pkg.sv */
// Shared sizes for the serial joystick front end
// Two 12-button controllers, all buttons active low
// Frame timing assumes a 26-slot chain with data in slots 2 to 25

`default_nettype none

package joy_pkg;

  //////////////////////////////////////////////////
  // Joystick word
  //////////////////////////////////////////////////

  // Bits in one joystick word
  localparam int joy_width = 12;

  // Word with every button released
  localparam logic [joy_width-1:0] joy_idle = '1;

  // Direction and fire bits handed to the game core
  localparam int dir_width = 6;

  //////////////////////////////////////////////////
  // Scan frame
  //////////////////////////////////////////////////

  localparam int frame_len  = 26;  // Slots 0 to 25
  localparam int first_slot = 2;   // Slots 0 and 1 carry no data

endpackage

`default_nettype wire
